// File: all.f
+incdir+.
dla_pkg.sv
pixel_ram.sv
walker_rng.sv
dla_engine.sv
axi_pixel_reader.sv
dla_top.sv
dla_sva.sv
tb_dla.sv

// File: axi_pixel_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "dla_consts.svh"

// --------------------------------------------------
// AXI4-Lite read slave onto RAM port B
// --------------------------------------------------
module axi_pixel_reader
(
   input  wire logic                  VGA_CTRL_CLK,
   input  wire logic                  reset,
   input  wire dla_pkg::axi_ar_t      ar,
   input  wire logic                  arvalid,
   output logic                       arready,
   output dla_pkg::axi_r_t            r,
   output logic                       rvalid,
   input  wire logic                  rready,
   output dla_pkg::grid_coord_t       pix_coord,
   input  wire logic                  pix_q
);

   localparam int cells = `DLA_GRID_W * `DLA_GRID_H;

   typedef enum logic [1:0] {rd_idle, rd_addr, rd_ram, rd_resp} rd_state_e;

   rd_state_e                  state;
   logic [`DLA_AXI_ADDR_W-3:0] word_addr;     // Byte address over 4
   dla_pkg::grid_coord_t       coord_q;
   logic                       err_q;
   dla_pkg::axi_r_t            r_q;

   assign word_addr = ar.addr[`DLA_AXI_ADDR_W-1:2];
   assign arready   = (state == rd_idle);      // One read at a time
   assign rvalid    = (state == rd_resp);
   assign r         = r_q;
   assign pix_coord = coord_q;

   always_ff @(posedge VGA_CTRL_CLK)
   begin
      if (reset)
         state <= rd_idle;
      else
         case (state)
            rd_idle: if (arvalid) state <= rd_addr;
            rd_addr: state <= rd_ram;          // RAM latches the coordinate
            rd_ram:  state <= rd_resp;         // Pixel bit on pix_q
            rd_resp: if (rready) state <= rd_idle;
            default: state <= rd_idle;
         endcase
   end

   // Payload registers
   always_ff @(posedge VGA_CTRL_CLK)
   begin
      if (state == rd_idle && arvalid)
      begin
         coord_q.x <= word_addr[`DLA_X_BITS-1:0];              // Index is y*64 + x
         coord_q.y <= word_addr[`DLA_X_BITS +: `DLA_Y_BITS];
         err_q     <= int'(word_addr) >= cells;                 // Past the grid
      end
      if (state == rd_ram)
      begin
         r_q.data <= err_q ? '0 : `DLA_AXI_DATA_W'(pix_q);
         r_q.resp <= err_q ? dla_pkg::resp_slverr : dla_pkg::resp_okay;
      end
   end

endmodule

`default_nettype wire

// File: dla_consts.svh
`ifndef DLA_CONSTS_SVH
`define DLA_CONSTS_SVH

// --------------------------------------------------
// Grid geometry
// --------------------------------------------------
`define DLA_X_BITS      6             // x coordinate width
`define DLA_Y_BITS      6             // y coordinate width
`define DLA_GRID_W      64
`define DLA_GRID_H      64

// Walker never leaves this box
`define DLA_LO          4
`define DLA_HI_X        56            // Grid width minus 8
`define DLA_HI_Y        56

`define DLA_SEED_X      32            // Center dot
`define DLA_SEED_Y      32
`define DLA_START_X     28            // First walker just left of center
`define DLA_START_Y     32

// --------------------------------------------------
// Random walk generators
// --------------------------------------------------
`define DLA_XR_BITS     31
`define DLA_YR_BITS     29
`define DLA_XR_TAP      27            // Second tap, first is the MSB
`define DLA_YR_TAP      26
`define DLA_LFSR_INIT   32'h55555555  // Alternating bits
`define DLA_SPAWN_BITS  5             // Taken just below the x MSB
`define DLA_SPAWN_OFS   16

// Host read port
`define DLA_AXI_ADDR_W  16
`define DLA_AXI_DATA_W  32

`endif

// File: dla_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "dla_consts.svh"

// --------------------------------------------------
// Aggregation FSM on RAM port A
// --------------------------------------------------
module dla_engine
(
   input  wire logic                  VGA_CTRL_CLK,
   input  wire logic                  reset,
   input  wire logic                  run,
   input  wire dla_pkg::grid_coord_t  walker,
   input  wire logic                  ram_q,
   output dla_pkg::ram_port_t         ram_req,
   output dla_pkg::walker_cmd_e       walker_cmd,
   output logic                       grid_ready,
   output logic [15:0]                particle_count
);

   localparam int cw = `DLA_X_BITS + `DLA_Y_BITS;
   localparam logic [cw-1:0] clr_last = `DLA_GRID_W * `DLA_GRID_H - 1;

   typedef enum logic [3:0]
   {
      st_idle,      // Reset parking, no write
      st_clear,     // Zero sweep
      st_seed,      // Center dot
      st_rd_l,      // Neighbour reads
      st_rd_r,
      st_rd_u,
      st_rd_d,
      st_sum,       // Last read lands
      st_test,
      st_draw
   } state_e;

   state_e          state;
   state_e          state_next;
   logic [cw-1:0]   clr_cnt;       // Sweep address
   logic [2:0]      sum;           // Neighbour count, 0 to 4
   logic            rd_valid;      // ram_q holds a neighbour this cycle
   logic            walk_phase;
   logic            reading;
   logic            hit;

   assign walk_phase = (state != st_idle) && (state != st_clear) && (state != st_seed);
   assign reading    = (state == st_rd_l) || (state == st_rd_r) ||
                       (state == st_rd_u) || (state == st_rd_d);
   assign hit        = (sum != 3'd0);

   // --------------------------------------------------
   // Port A request
   // --------------------------------------------------
   always_comb
   begin
      ram_req.coord = walker;
      ram_req.we    = 1'b0;
      ram_req.data  = 1'b0;
      case (state)
         st_clear:
         begin
            ram_req.coord = dla_pkg::grid_coord_t'(clr_cnt);
            ram_req.we    = 1'b1;
         end
         st_seed:
         begin
            ram_req.coord.x = `DLA_X_BITS'(`DLA_SEED_X);
            ram_req.coord.y = `DLA_Y_BITS'(`DLA_SEED_Y);
            ram_req.we      = 1'b1;
            ram_req.data    = 1'b1;
         end
         st_rd_l: ram_req.coord.x = walker.x - `DLA_X_BITS'(1);   // Left
         st_rd_r: ram_req.coord.x = walker.x + `DLA_X_BITS'(1);   // Right
         st_rd_u: ram_req.coord.y = walker.y - `DLA_Y_BITS'(1);   // Up
         st_rd_d: ram_req.coord.y = walker.y + `DLA_Y_BITS'(1);   // Down
         st_draw:
         begin
            ram_req.we   = run;                // Stuck walker pixel
            ram_req.data = 1'b1;
         end
         default:
         begin
         end
      endcase
   end

   // Paused walk only churns the generators
   always_comb
   begin
      if (walk_phase && !run)
         walker_cmd = dla_pkg::cmd_churn;
      else if (state == st_draw)
         walker_cmd = dla_pkg::cmd_respawn;
      else if (state == st_test && !hit)
         walker_cmd = dla_pkg::cmd_step;
      else
         walker_cmd = dla_pkg::cmd_hold;
   end

   // --------------------------------------------------
   // Next state
   // --------------------------------------------------
   always_comb
   begin
      state_next = state;
      case (state)
         st_idle:  state_next = st_clear;
         st_clear: if (clr_cnt == clr_last) state_next = st_seed;
         st_seed:  state_next = st_rd_l;
         st_rd_l:  state_next = st_rd_r;
         st_rd_r:  state_next = st_rd_u;
         st_rd_u:  state_next = st_rd_d;
         st_rd_d:  state_next = st_sum;
         st_sum:   state_next = st_test;
         st_test:  state_next = hit ? st_draw : st_rd_l;
         st_draw:  state_next = st_rd_l;
         default:  state_next = st_idle;
      endcase
      if (walk_phase && !run)
         state_next = state;                   // Freeze between states
   end

   always_ff @(posedge VGA_CTRL_CLK)
   begin
      if (reset)
      begin
         state          <= st_idle;
         clr_cnt        <= '0;
         sum            <= 3'd0;
         rd_valid       <= 1'b0;
         grid_ready     <= 1'b0;
         particle_count <= 16'd0;
      end
      else
      begin
         state    <= state_next;
         rd_valid <= reading && run;           // Frozen reads are not counted
         if (rd_valid)
            sum <= sum + {2'b00, ram_q};
         if (state == st_clear)
            clr_cnt <= clr_cnt + cw'(1);
         if (state == st_seed)
            grid_ready <= 1'b1;                // Stays up until reset
         if (state == st_test && run)
            sum <= 3'd0;                       // Fresh count for next position
         if (state == st_draw && run)
            particle_count <= particle_count + 16'd1;
      end
   end

endmodule

`default_nettype wire

// File: dla_pkg.sv
`default_nettype none

`include "dla_consts.svh"

package dla_pkg;

   // Pixel position, x in the upper bits so {x, y} is the RAM index
   typedef struct packed
   {
      logic [`DLA_X_BITS-1:0] x;
      logic [`DLA_Y_BITS-1:0] y;
   } grid_coord_t;

   // Engine request into RAM port A
   typedef struct packed
   {
      grid_coord_t coord;
      logic        we;         // One cycle per write
      logic        data;       // Pixel value to write
   } ram_port_t;

   // What the walker does on the next clock
   typedef enum logic [1:0]
   {
      cmd_hold    = 2'd0,      // Nothing moves
      cmd_step    = 2'd1,      // Random move plus LFSR shift
      cmd_respawn = 2'd2,      // New walker on an edge
      cmd_churn   = 2'd3       // LFSR shift only, paused
   } walker_cmd_e;

   // AXI4-Lite read address channel payload
   typedef struct packed
   {
      logic [`DLA_AXI_ADDR_W-1:0] addr;   // Byte address
      logic [2:0]                 prot;
   } axi_ar_t;

   // AXI4-Lite read data channel payload
   typedef struct packed
   {
      logic [`DLA_AXI_DATA_W-1:0] data;
      logic [1:0]                 resp;
   } axi_r_t;

   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

// File: dla_sva.sv
`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------
// AXI read channel rules for the pixel reader
// --------------------------------------------------
module dla_sva
(
   input  wire logic             VGA_CTRL_CLK,
   input  wire logic             reset,
   input  wire logic             arready,
   input  wire dla_pkg::axi_r_t  r,
   input  wire logic             rvalid,
   input  wire logic             rready
);

   // Response held until the master takes it
   rvalid_hold: assert property (@(posedge VGA_CTRL_CLK) disable iff (reset)
      rvalid && !rready |=> rvalid)
      else $error("rvalid dropped before rready");

   r_stable: assert property (@(posedge VGA_CTRL_CLK) disable iff (reset)
      rvalid && !rready |=> $stable(r))
      else $error("read payload changed under back-pressure");

   // One read in flight
   ar_blocked: assert property (@(posedge VGA_CTRL_CLK) disable iff (reset)
      rvalid |-> !arready)
      else $error("arready high during a response");

   resp_legal: assert property (@(posedge VGA_CTRL_CLK) disable iff (reset)
      rvalid |-> (r.resp == dla_pkg::resp_okay || r.resp == dla_pkg::resp_slverr))
      else $error("illegal read response code");

endmodule

bind axi_pixel_reader dla_sva u_sva
(
   .VGA_CTRL_CLK (VGA_CTRL_CLK),
   .reset        (reset),
   .arready      (arready),
   .r            (r),
   .rvalid       (rvalid),
   .rready       (rready)
);

`default_nettype wire

// File: dla_top.sv
`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------
// DLA engine with frame buffer and host read port
// --------------------------------------------------
module dla_top
(
   input  wire logic                  VGA_CTRL_CLK,
   input  wire logic                  reset,
   input  wire logic                  run,              // Low pauses the walk
   output logic                       grid_ready,
   output logic [15:0]                particle_count,
   input  wire dla_pkg::axi_ar_t      s_axi_ar,
   input  wire logic                  s_axi_arvalid,
   output logic                       s_axi_arready,
   output dla_pkg::axi_r_t            s_axi_r,
   output logic                       s_axi_rvalid,
   input  wire logic                  s_axi_rready
);

   dla_pkg::ram_port_t    a_req;        // Engine to port A
   logic                  a_q;
   dla_pkg::grid_coord_t  walker;       // Current walker position
   dla_pkg::walker_cmd_e  walker_cmd;
   dla_pkg::grid_coord_t  pix_coord;    // Reader to port B
   logic                  pix_q;

   dla_engine u_engine
   (
      .VGA_CTRL_CLK   (VGA_CTRL_CLK),
      .reset          (reset),
      .run            (run),
      .walker         (walker),
      .ram_q          (a_q),
      .ram_req        (a_req),
      .walker_cmd     (walker_cmd),
      .grid_ready     (grid_ready),
      .particle_count (particle_count)
   );

   walker_rng u_walker
   (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .reset        (reset),
      .cmd          (walker_cmd),
      .walker       (walker)
   );

   pixel_ram u_ram
   (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .a_req        (a_req),
      .a_q          (a_q),
      .b_coord      (pix_coord),
      .b_q          (pix_q)
   );

   axi_pixel_reader u_reader
   (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .reset        (reset),
      .ar           (s_axi_ar),
      .arvalid      (s_axi_arvalid),
      .arready      (s_axi_arready),
      .r            (s_axi_r),
      .rvalid       (s_axi_rvalid),
      .rready       (s_axi_rready),
      .pix_coord    (pix_coord),
      .pix_q        (pix_q)
   );

endmodule

`default_nettype wire

// File: pixel_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "dla_consts.svh"

// --------------------------------------------------
// One bit per pixel, two ports on one clock
// --------------------------------------------------
module pixel_ram
(
   input  wire logic                  VGA_CTRL_CLK,
   input  wire dla_pkg::ram_port_t    a_req,     // Engine side, read and write
   output logic                       a_q,
   input  wire dla_pkg::grid_coord_t  b_coord,   // Host side, read only
   output logic                       b_q
);

   localparam int cells = `DLA_GRID_W * `DLA_GRID_H;

   // Index is the {x, y} concatenation
   logic mem [0:cells-1];

   // Port A
   // Read returns the old bit when the same cycle writes
   always_ff @(posedge VGA_CTRL_CLK)
   begin
      if (a_req.we)
      begin
         mem[a_req.coord] <= a_req.data;
      end
      a_q <= mem[a_req.coord];   // Valid one cycle after request
   end

   // Port B
   always_ff @(posedge VGA_CTRL_CLK)
   begin
      b_q <= mem[b_coord];       // Registered like port A
   end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the DLA testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dla -f all.f -o tb_dla_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed"
   exit $status
fi

./obj_dir/tb_dla_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed"
   exit $status
fi
exit 0

// File: tb_dla.sv
`timescale 1ns/1ps
`default_nettype none

`include "dla_consts.svh"

module tb_dla;

   localparam int cells     = `DLA_GRID_W * `DLA_GRID_H;
   localparam int seed_idx  = `DLA_SEED_Y * `DLA_GRID_W + `DLA_SEED_X;
   localparam int long_wait = 20_000_000;   // Cycles allowed for particle growth

   logic                 VGA_CTRL_CLK;
   logic                 reset;
   logic                 run;
   logic                 grid_ready;
   logic [15:0]          particle_count;
   dla_pkg::axi_ar_t     s_axi_ar;
   logic                 s_axi_arvalid;
   logic                 s_axi_arready;
   dla_pkg::axi_r_t      s_axi_r;
   logic                 s_axi_rvalid;
   logic                 s_axi_rready;

   int                   seed = 32'hc521;   // Back-pressure stalls
   logic [cells-1:0]     grid_a;            // Grid snapshots indexed y*64 + x
   logic [cells-1:0]     grid_b;
   bit                   fail_shown;
   bit                   pass_shown;

   dla_top uut
   (
      .VGA_CTRL_CLK   (VGA_CTRL_CLK),
      .reset          (reset),
      .run            (run),
      .grid_ready     (grid_ready),
      .particle_count (particle_count),
      .s_axi_ar       (s_axi_ar),
      .s_axi_arvalid  (s_axi_arvalid),
      .s_axi_arready  (s_axi_arready),
      .s_axi_r        (s_axi_r),
      .s_axi_rvalid   (s_axi_rvalid),
      .s_axi_rready   (s_axi_rready)
   );

   initial
   begin
      VGA_CTRL_CLK = 1'b0;
      forever #10 VGA_CTRL_CLK = ~VGA_CTRL_CLK;   // 20 ns period
   end

   // --------------------------------------------------
   // Failure reporting and the compare task
   // --------------------------------------------------
   task automatic abort_run(input string why);
      fail_shown = 1'b1;
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp)
         abort_run($sformatf("[FAIL] time %0t, %s: got 0x%0h, expected 0x%0h",
                             $time, what, got, exp));
   endtask

   function automatic int pix_index(input int x, input int y);
      return y * `DLA_GRID_W + x;
   endfunction

   // --------------------------------------------------
   // Step-level reference walk without pauses
   // --------------------------------------------------
   function automatic logic [cells-1:0] grow_reference(input int n);
      logic [cells-1:0]        g;
      logic [`DLA_XR_BITS-1:0] xr;
      logic [`DLA_YR_BITS-1:0] yr;
      logic [31:0]             init;
      logic                    xm;
      logic                    ym;
      logic                    near;
      int                      x;
      int                      y;
      int                      spawn;
      int                      stuck;
      int                      guard;
      init  = `DLA_LFSR_INIT;
      xr    = init[`DLA_XR_BITS-1:0];
      yr    = init[`DLA_YR_BITS-1:0];
      g     = '0;
      g[seed_idx] = 1'b1;
      x     = `DLA_START_X;
      y     = `DLA_START_Y;
      stuck = 0;
      guard = 0;
      while (stuck < n && guard < long_wait)
      begin
         xm   = xr[`DLA_XR_BITS-1];             // Decisions on pre-shift bits
         ym   = yr[`DLA_YR_BITS-1];
         near = g[pix_index(x - 1, y)] | g[pix_index(x + 1, y)] |
                g[pix_index(x, y - 1)] | g[pix_index(x, y + 1)];
         if (near)
         begin
            g[pix_index(x, y)] = 1'b1;          // Sticks
            stuck++;
            spawn = int'(xr[`DLA_XR_BITS-2 -: `DLA_SPAWN_BITS]) + `DLA_SPAWN_OFS;
            if (xm)
            begin
               x = spawn;                       // Top or bottom edge
               y = ym ? `DLA_HI_Y : `DLA_LO;
            end
            else
            begin
               y = spawn;
               x = ym ? `DLA_HI_X : `DLA_LO;
            end
         end
         else
         begin
            if (xm && x < `DLA_HI_X)
               x++;
            else if (!xm && x > `DLA_LO)
               x--;
            if (ym && y < `DLA_HI_Y)
               y++;
            else if (!ym && y > `DLA_LO)
               y--;
         end
         xr = {xr[`DLA_XR_BITS-2:0], xm ^ xr[`DLA_XR_TAP]};
         yr = {yr[`DLA_YR_BITS-2:0], ym ^ yr[`DLA_YR_TAP]};
         guard++;
      end
      return g;
   endfunction

   // --------------------------------------------------
   // AXI read that starts and ends on a falling edge
   // --------------------------------------------------
   task automatic axi_read(input logic [15:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      dla_pkg::axi_r_t held;
      int              t;
      int              stall;
      s_axi_ar.addr = addr;
      s_axi_ar.prot = 3'b000;
      s_axi_arvalid = 1'b1;
      t = 0;
      while (!s_axi_arready)
      begin
         @(negedge VGA_CTRL_CLK);
         t++;
         if (t > 100)
            abort_run("Timeout waiting for arready");
      end
      @(negedge VGA_CTRL_CLK);                  // AR handshake on the edge just passed
      s_axi_arvalid = 1'b0;
      t = 0;
      while (!s_axi_rvalid)
      begin
         @(negedge VGA_CTRL_CLK);
         t++;
         if (t > 100)
            abort_run("Timeout waiting for rvalid");
      end
      check_eq(32'(t), 32'd2, "rvalid latency after AR handshake");
      check_eq(32'(s_axi_arready), 32'd0, "arready while rvalid");
      held  = s_axi_r;
      stall = $random(seed) & 32'h3;            // 0 to 3 cycles of back-pressure
      repeat (stall)
      begin
         @(negedge VGA_CTRL_CLK);
         check_eq(32'(s_axi_rvalid), 32'd1, "rvalid under back-pressure");
         check_eq(s_axi_r.data, held.data, "rdata under back-pressure");
         check_eq(32'(s_axi_r.resp), 32'(held.resp), "rresp under back-pressure");
      end
      s_axi_rready = 1'b1;
      @(negedge VGA_CTRL_CLK);
      s_axi_rready = 1'b0;
      data = held.data;
      resp = held.resp;
   endtask

   task automatic read_grid(output logic [cells-1:0] g);
      logic [31:0] d;
      logic [1:0]  rs;
      for (int i = 0; i < cells; i++)
      begin
         axi_read(16'(i * 4), d, rs);
         check_eq(32'(rs), 32'(dla_pkg::resp_okay), "in-range rresp");
         check_eq(d & 32'hffff_fffe, 32'd0, "rdata bits above bit 0");
         g[i] = d[0];
      end
   endtask

   task automatic compare_grids(input logic [cells-1:0] got, input logic [cells-1:0] exp,
                                input string what);
      for (int i = 0; i < cells; i++)
      begin
         if (got[i] !== exp[i])
            check_eq(32'(got[i]), 32'(exp[i]), $sformatf("%s at (%0d,%0d)", what,
                     i % `DLA_GRID_W, i / `DLA_GRID_W));
      end
   endtask

   task automatic wait_count(input int target);
      int t;
      t = 0;
      while (int'(particle_count) < target)
      begin
         @(negedge VGA_CTRL_CLK);
         t++;
         if (t > long_wait)
            abort_run("Timeout waiting for particle count to grow");
      end
   endtask

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------
   initial
   begin
      logic [31:0] d;
      logic [1:0]  rs;
      logic        near;
      int          t;
      int          n1;
      int          n2;
      int          x;
      int          y;
      reset         = 1'b1;
      run           = 1'b1;                     // Walk enabled from the start
      s_axi_ar      = '0;
      s_axi_arvalid = 1'b0;
      s_axi_rready  = 1'b0;
      fail_shown    = 1'b0;
      pass_shown    = 1'b0;
      repeat (16) @(negedge VGA_CTRL_CLK);
      reset = 1'b0;
      check_eq(32'(grid_ready), 32'd0, "grid_ready after reset");
      check_eq(32'(particle_count), 32'd0, "particle_count after reset");
      check_eq(32'(s_axi_arready), 32'd1, "arready after reset");
      check_eq(32'(s_axi_rvalid), 32'd0, "rvalid after reset");

      // Clear sweep plus seed
      t = 0;
      while (!grid_ready)
      begin
         @(negedge VGA_CTRL_CLK);
         t++;
         if (t > 5000)
            abort_run("Timeout waiting for grid_ready");
      end
      check_eq(32'(t > cells), 32'd1, "grid_ready before full clear");
      read_grid(grid_a);
      n1 = int'(particle_count);
      // Walk runs during the read so only pixels of the first n1 particles may show
      compare_grids(grid_a & ~grow_reference(n1), '0, "pixel beyond reference after clear");
      check_eq(32'(grid_a[seed_idx]), 32'd1, "seed pixel");

      // Growth against the reference
      wait_count(8);
      run = 1'b0;
      repeat (10) @(negedge VGA_CTRL_CLK);
      n1 = int'(particle_count);
      read_grid(grid_a);
      compare_grids(grid_a, grow_reference(n1), "grown grid");

      // Paused walk leaves grid and count alone
      repeat (300)
      begin
         @(negedge VGA_CTRL_CLK);
         check_eq(32'(particle_count), 32'(n1), "particle_count while paused");
      end
      read_grid(grid_b);
      compare_grids(grid_b, grid_a, "paused grid");

      // Churned LFSRs leave only the invariants after the resume
      run = 1'b1;
      wait_count(n1 + 10);
      run = 1'b0;
      repeat (10) @(negedge VGA_CTRL_CLK);
      n2 = int'(particle_count);
      read_grid(grid_b);
      // Walker landing diagonally on the cluster rewrites a set pixel
      check_eq(32'($countones(grid_b) <= n2 + 1), 32'd1, "set pixels above count plus one");
      for (int i = 0; i < cells; i++)
      begin
         if (grid_a[i])
            check_eq(32'(grid_b[i]), 32'd1, "pixel lost after resume");
         if (grid_b[i])
         begin
            x = i % `DLA_GRID_W;
            y = i / `DLA_GRID_W;
            check_eq(32'(x >= `DLA_LO && x <= `DLA_HI_X && y >= `DLA_LO && y <= `DLA_HI_Y),
                     32'd1, "set pixel outside walk box");
            near = grid_b[i - 1] | grid_b[i + 1] |
                   grid_b[i - `DLA_GRID_W] | grid_b[i + `DLA_GRID_W];
            if (i != seed_idx)
               check_eq(32'(near), 32'd1, "set pixel without set neighbour");
         end
      end

      // Out of range words
      axi_read(16'h4000, d, rs);
      check_eq(32'(rs), 32'(dla_pkg::resp_slverr), "rresp at word 4096");
      check_eq(d, 32'd0, "rdata at word 4096");
      axi_read(16'hfffc, d, rs);
      check_eq(32'(rs), 32'(dla_pkg::resp_slverr), "rresp at last word");
      check_eq(d, 32'd0, "rdata at last word");
      axi_read(16'(seed_idx * 4), d, rs);       // Back in range after an error
      check_eq(32'(rs), 32'(dla_pkg::resp_okay), "rresp at seed");
      check_eq(d, 32'd1, "rdata at seed");

      pass_shown = 1'b1;
      $display(">>> PASS");
      $finish;
   end

   // Ended some other way, such as an assertion stop
   final
   begin
      if (!pass_shown && !fail_shown)
         $display(">>> FAIL");
   end

endmodule

`default_nettype wire

// File: walker_rng.sv
`timescale 1ns/1ps
`default_nettype none

`include "dla_consts.svh"

// --------------------------------------------------
// Two XOR shift registers and the walker position
// --------------------------------------------------
module walker_rng
(
   input  wire logic                  VGA_CTRL_CLK,
   input  wire logic                  reset,
   input  wire dla_pkg::walker_cmd_e  cmd,
   output dla_pkg::grid_coord_t       walker
);

   localparam logic [31:0] lfsr_init = `DLA_LFSR_INIT;

   // Walk box edges at coordinate width
   localparam logic [`DLA_X_BITS-1:0] lo_x = `DLA_LO;
   localparam logic [`DLA_Y_BITS-1:0] lo_y = `DLA_LO;
   localparam logic [`DLA_X_BITS-1:0] hi_x = `DLA_HI_X;
   localparam logic [`DLA_Y_BITS-1:0] hi_y = `DLA_HI_Y;

   logic [`DLA_XR_BITS-1:0]    x_rand;
   logic [`DLA_YR_BITS-1:0]    y_rand;
   logic                       x_msb;
   logic                       y_msb;
   logic                       x_fb;
   logic                       y_fb;
   logic [`DLA_SPAWN_BITS-1:0] spawn_field;
   logic [`DLA_X_BITS-1:0]     spawn_x;
   logic [`DLA_Y_BITS-1:0]     spawn_y;

   assign x_msb = x_rand[`DLA_XR_BITS-1];
   assign y_msb = y_rand[`DLA_YR_BITS-1];
   assign x_fb  = x_msb ^ x_rand[`DLA_XR_TAP];    // Feedback bit
   assign y_fb  = y_msb ^ y_rand[`DLA_YR_TAP];

   // Spawn offset along the chosen edge
   assign spawn_field = x_rand[`DLA_XR_BITS-2 -: `DLA_SPAWN_BITS];
   assign spawn_x     = `DLA_X_BITS'(spawn_field) + `DLA_X_BITS'(`DLA_SPAWN_OFS);
   assign spawn_y     = `DLA_Y_BITS'(spawn_field) + `DLA_Y_BITS'(`DLA_SPAWN_OFS);

   always_ff @(posedge VGA_CTRL_CLK)
   begin
      if (reset)
      begin
         x_rand   <= lfsr_init[`DLA_XR_BITS-1:0];
         y_rand   <= lfsr_init[`DLA_YR_BITS-1:0];
         walker.x <= `DLA_X_BITS'(`DLA_START_X);
         walker.y <= `DLA_Y_BITS'(`DLA_START_Y);
      end
      else
      begin
         // Every command but hold turns both generators once
         if (cmd != dla_pkg::cmd_hold)
         begin
            x_rand <= {x_rand[`DLA_XR_BITS-2:0], x_fb};
            y_rand <= {y_rand[`DLA_YR_BITS-2:0], y_fb};
         end

         case (cmd)
            dla_pkg::cmd_step:
            begin
               // One step in x, clamped to the box
               if (walker.x < hi_x && x_msb)
                  walker.x <= walker.x + `DLA_X_BITS'(1);
               else if (walker.x > lo_x && !x_msb)
                  walker.x <= walker.x - `DLA_X_BITS'(1);
               // Same rule in y
               if (walker.y < hi_y && y_msb)
                  walker.y <= walker.y + `DLA_Y_BITS'(1);
               else if (walker.y > lo_y && !y_msb)
                  walker.y <= walker.y - `DLA_Y_BITS'(1);
            end
            dla_pkg::cmd_respawn:
            begin
               if (x_msb)
               begin
                  walker.x <= spawn_x;                 // Top or bottom edge
                  walker.y <= y_msb ? hi_y : lo_y;
               end
               else
               begin
                  walker.y <= spawn_y;                 // Left or right edge
                  walker.x <= y_msb ? hi_x : lo_x;
               end
            end
            default:
            begin
               // Hold and churn leave the walker alone
            end
         endcase
      end
   end

endmodule

`default_nettype wire
